/* lcd_pkg.sv */
// shared constants, bus types and the panel init table, imported by the lcd controller modules
package lcd_pkg;

    localparam int COORD_W = 9;             // 0..511 covers 320x480
    localparam int H_RES   = 320;
    localparam int V_RES   = 480;

    // panel command bytes
    localparam logic [7:0] CMD_CASET = 8'h2A;
    localparam logic [7:0] CMD_PASET = 8'h2B;
    localparam logic [7:0] CMD_RAMWR = 8'h2C;
    localparam logic [7:0] CMD_RDID  = 8'hD3;

    // strobe phase lengths in pclk cycles
    localparam int WR_LOW_CYC  = 2;
    localparam int WR_HIGH_CYC = 2;
    localparam int RD_LOW_CYC  = 4;
    localparam int RD_HIGH_CYC = 2;
    localparam int PHASE_W     = 3;         // holds the longest phase count

    localparam int RST_HOLD_CYC   = 16;
    localparam int INIT_LEN       = 8;
    localparam int FILL_CMD_WORDS = 11;     // caset + 4, paset + 4, ramwr

    // arbiter grant codes
    localparam logic [1:0] GNT_INIT = 2'd0;
    localparam logic [1:0] GNT_FILL = 2'd1;
    localparam logic [1:0] GNT_ID   = 2'd2;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // one bus word, read as a command byte or as a pixel depending on rs
    typedef union packed {
        struct packed {
            logic [7:0] pad;
            logic [7:0] opcode;
        } cmd;
        rgb565_t pix;
    } lcd_word_u;

    typedef struct packed {
        logic       rs;                     // 1 = data byte
        logic [7:0] data;
    } init_entry_t;

    typedef struct packed {
        logic [COORD_W-1:0] x0;
        logic [COORD_W-1:0] y0;
        logic [COORD_W-1:0] x1;
        logic [COORD_W-1:0] y1;
        rgb888_t            color;
    } fill_req_t;

    typedef struct packed {
        logic      rs;                      // 0 command, 1 data
        logic      rd;                      // read cycle
        lcd_word_u word;
    } bus_req_t;

    // sleep out, 16 bpp, scan direction, inversion control, display on
    localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
        '{1'b0, 8'h11},
        '{1'b0, 8'h3A},
        '{1'b1, 8'h55},
        '{1'b0, 8'h36},
        '{1'b1, 8'h48},
        '{1'b0, 8'hB4},
        '{1'b1, 8'h02},
        '{1'b0, 8'h29}
    };

endpackage

/* lcd_init_seq.sv */
// panel reset hold followed by the fixed init table, owns the bus until init done
module lcd_init_seq import lcd_pkg::*; (
    input  logic     pclk,
    input  logic     rst_n,
    input  logic     done_i,
    output logic     lcd_rst_o,
    output logic     issue_o,
    output bus_req_t req_o,
    output logic     init_done_o
);

    logic [$clog2(RST_HOLD_CYC)-1:0] hold_cnt;
    logic [$clog2(INIT_LEN)-1:0]     idx;
    logic                            rst_rel;   // panel reset released
    logic                            pend;      // word to issue this cycle
    logic                            init_done;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            hold_cnt  <= '0;
            idx       <= '0;
            rst_rel   <= 1'b0;
            pend      <= 1'b0;
            init_done <= 1'b0;
        end else begin
            pend <= 1'b0;
            if (!rst_rel) begin
                hold_cnt <= hold_cnt + 1'b1;
                if (hold_cnt == ($clog2(RST_HOLD_CYC))'(RST_HOLD_CYC - 1)) begin
                    rst_rel <= 1'b1;
                    pend    <= 1'b1;    // first entry right after release
                end
            end else if (done_i && !init_done) begin
                if (idx == ($clog2(INIT_LEN))'(INIT_LEN - 1)) begin
                    init_done <= 1'b1;
                end else begin
                    idx  <= idx + 1'b1;
                    pend <= 1'b1;
                end
            end
        end
    end

    // table entry onto the bus, rs straight from the entry
    always_comb begin
        req_o                 = '0;
        req_o.rs              = INIT_TABLE[idx].rs;
        req_o.word.cmd.opcode = INIT_TABLE[idx].data;
    end

    assign issue_o     = pend;
    assign lcd_rst_o   = rst_rel;
    assign init_done_o = init_done;

endmodule

/* lcd_fill_engine.sv */
// rectangle fill, emits the column/page window, ramwr and one rgb565 word per pixel
module lcd_fill_engine import lcd_pkg::*; (
    input  logic      pclk,
    input  logic      rst_n,
    input  logic      start_i,
    input  fill_req_t fill_i,
    input  logic      done_i,
    output logic      issue_o,
    output bus_req_t  req_o,
    output logic      fill_done_o,
    output logic      busy_o
);

    logic [COORD_W-1:0]   cx0, cx1, cy0, cy1;   // clamped corners
    logic [COORD_W-1:0]   nx0, nx1, ny0, ny1;   // normalised corners
    logic [2*COORD_W-1:0] area;
    logic [COORD_W-1:0]   x0_q, x1_q, y0_q, y1_q;
    rgb565_t              color_q;
    logic [15:0]          x0_w, x1_w, y0_w, y1_w;
    logic [3:0]           step;
    logic [2*COORD_W-1:0] pix_cnt;
    logic                 busy, pend, fill_done;

    always_comb begin
        cx0 = (fill_i.x0 > COORD_W'(H_RES - 1)) ? COORD_W'(H_RES - 1) : fill_i.x0;
        cx1 = (fill_i.x1 > COORD_W'(H_RES - 1)) ? COORD_W'(H_RES - 1) : fill_i.x1;
        cy0 = (fill_i.y0 > COORD_W'(V_RES - 1)) ? COORD_W'(V_RES - 1) : fill_i.y0;
        cy1 = (fill_i.y1 > COORD_W'(V_RES - 1)) ? COORD_W'(V_RES - 1) : fill_i.y1;
        nx0 = (cx1 < cx0) ? cx1 : cx0;
        nx1 = (cx1 < cx0) ? cx0 : cx1;
        ny0 = (cy1 < cy0) ? cy1 : cy0;
        ny1 = (cy1 < cy0) ? cy0 : cy1;
        area = ((2*COORD_W)'(nx1 - nx0) + 1'b1) * ((2*COORD_W)'(ny1 - ny0) + 1'b1);
    end

    // request payload, loaded on accepted start
    always_ff @(posedge pclk) begin
        if (start_i && !busy) begin
            x0_q    <= nx0;
            x1_q    <= nx1;
            y0_q    <= ny0;
            y1_q    <= ny1;
            color_q <= '{fill_i.color.r[7:3], fill_i.color.g[7:2], fill_i.color.b[7:3]};
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            pend      <= 1'b0;
            step      <= '0;
            pix_cnt   <= '0;
            fill_done <= 1'b0;
        end else begin
            pend      <= 1'b0;
            fill_done <= 1'b0;
            if (!busy) begin
                if (start_i) begin
                    busy    <= 1'b1;
                    pend    <= 1'b1;
                    step    <= '0;
                    pix_cnt <= area;
                end
            end else if (done_i) begin
                if (step != 4'(FILL_CMD_WORDS)) begin
                    step <= step + 1'b1;    // last step value means pixel phase
                    pend <= 1'b1;
                end else if (pix_cnt == 1) begin
                    busy      <= 1'b0;
                    fill_done <= 1'b1;
                end else begin
                    pix_cnt <= pix_cnt - 1'b1;
                    pend    <= 1'b1;
                end
            end
        end
    end

    assign x0_w = 16'(x0_q);
    assign x1_w = 16'(x1_q);
    assign y0_w = 16'(y0_q);
    assign y1_w = 16'(y1_q);

    always_comb begin
        req_o    = '0;
        req_o.rs = 1'b1;
        case (step)
            4'd0:    begin req_o.rs = 1'b0; req_o.word.cmd.opcode = CMD_CASET; end
            4'd1:    req_o.word.cmd.opcode = x0_w[15:8];
            4'd2:    req_o.word.cmd.opcode = x0_w[7:0];
            4'd3:    req_o.word.cmd.opcode = x1_w[15:8];
            4'd4:    req_o.word.cmd.opcode = x1_w[7:0];
            4'd5:    begin req_o.rs = 1'b0; req_o.word.cmd.opcode = CMD_PASET; end
            4'd6:    req_o.word.cmd.opcode = y0_w[15:8];
            4'd7:    req_o.word.cmd.opcode = y0_w[7:0];
            4'd8:    req_o.word.cmd.opcode = y1_w[15:8];
            4'd9:    req_o.word.cmd.opcode = y1_w[7:0];
            4'd10:   begin req_o.rs = 1'b0; req_o.word.cmd.opcode = CMD_RAMWR; end
            default: req_o.word.pix = color_q;
        endcase
    end

    assign issue_o     = pend;
    assign fill_done_o = fill_done;
    assign busy_o      = busy;

endmodule

/* lcd_id_reader.sv */
// read-id sequence, one command write and four reads, returns the 24-bit panel id
module lcd_id_reader import lcd_pkg::*; (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        start_i,
    input  logic        done_i,
    input  logic [15:0] rdata_i,
    output logic        issue_o,
    output bus_req_t    req_o,
    output logic [23:0] id_o,
    output logic        id_valid_o,
    output logic        busy_o
);

    logic [2:0]  cnt;       // 0 = command, 1..4 = reads
    logic        busy, pend, id_valid;
    logic [23:0] id_q;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            cnt      <= '0;
            busy     <= 1'b0;
            pend     <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            pend     <= 1'b0;
            id_valid <= 1'b0;
            if (!busy) begin
                if (start_i) begin
                    busy <= 1'b1;
                    pend <= 1'b1;
                    cnt  <= '0;
                end
            end else if (done_i) begin
                if (cnt == 3'd4) begin
                    busy     <= 1'b0;
                    id_valid <= 1'b1;
                end else begin
                    cnt  <= cnt + 1'b1;
                    pend <= 1'b1;
                end
            end
        end
    end

    // first read is a dummy, the next three hold the id
    always_ff @(posedge pclk) begin
        if (busy && done_i && cnt >= 3'd2) begin
            id_q <= {id_q[15:0], rdata_i[7:0]};
        end
    end

    always_comb begin
        req_o = '0;
        if (cnt == 3'd0) begin
            req_o.word.cmd.opcode = CMD_RDID;
        end else begin
            req_o.rs = 1'b1;
            req_o.rd = 1'b1;
        end
    end

    assign issue_o    = pend;
    assign id_o       = id_q;
    assign id_valid_o = id_valid;
    assign busy_o     = busy;

endmodule

/* lcd_bus_arbiter.sv */
// start gating, bus lock and word/done routing between init, fill and id sources
module lcd_bus_arbiter import lcd_pkg::*; (
    input  logic     pclk,
    input  logic     rst_n,
    input  logic     init_done_i,
    input  logic     fill_start_i,
    input  logic     id_start_i,
    input  logic     fill_busy_i,
    input  logic     id_busy_i,
    output logic     fill_start_o,
    output logic     id_start_o,
    input  logic     init_issue_i,
    input  logic     fill_issue_i,
    input  logic     id_issue_i,
    input  bus_req_t init_req_i,
    input  bus_req_t fill_req_i,
    input  bus_req_t id_req_i,
    output logic     issue_o,
    output bus_req_t req_o,
    input  logic     done_i,
    output logic     init_done_o,
    output logic     fill_done_o,
    output logic     id_done_o
);

    logic [1:0] grant;
    logic       lock;
    logic       lock_busy;

    // fill wins a tie, anything not forwarded is dropped
    assign fill_start_o = fill_start_i && init_done_i && !lock;
    assign id_start_o   = id_start_i && init_done_i && !lock && !fill_start_i;

    assign lock_busy = (grant == GNT_FILL) ? fill_busy_i : id_busy_i;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            grant <= GNT_INIT;
            lock  <= 1'b0;
        end else if (fill_start_o) begin
            grant <= GNT_FILL;
            lock  <= 1'b1;
        end else if (id_start_o) begin
            grant <= GNT_ID;
            lock  <= 1'b1;
        end else if (lock && !lock_busy) begin
            lock <= 1'b0;   // owner finished
        end
    end

    always_comb begin
        case (grant)
            GNT_FILL: begin issue_o = fill_issue_i; req_o = fill_req_i; end
            GNT_ID:   begin issue_o = id_issue_i;   req_o = id_req_i;   end
            default:  begin issue_o = init_issue_i; req_o = init_req_i; end
        endcase
    end

    assign init_done_o = done_i && (grant == GNT_INIT);
    assign fill_done_o = done_i && (grant == GNT_FILL);
    assign id_done_o   = done_i && (grant == GNT_ID);

endmodule

/* lcd_bus_timing.sv */
// 8080 bus cycle generator, one word per issue with fixed strobe low and high phases
module lcd_bus_timing import lcd_pkg::*; (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        issue_i,
    input  bus_req_t    req_i,
    input  logic [15:0] lcd_data_i,
    output logic        lcd_cs_o,
    output logic        lcd_rs_o,
    output logic        lcd_wr_o,
    output logic        lcd_rd_o,
    output logic        lcd_data_oe_o,
    output logic [15:0] lcd_data_o,
    output logic        done_o,
    output logic [15:0] rdata_o
);

    bus_req_t             req_q;
    logic                 busy;
    logic [PHASE_W-1:0]   cnt;
    logic [PHASE_W-1:0]   last_cnt;
    logic                 last;
    logic [15:0]          din_q;    // input flop on the pad side
    logic [15:0]          rdata_q;

    assign last_cnt = req_q.rd ? PHASE_W'(RD_LOW_CYC + RD_HIGH_CYC - 1)
                               : PHASE_W'(WR_LOW_CYC + WR_HIGH_CYC - 1);
    assign last     = busy && (cnt == last_cnt);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (!busy) begin
            busy <= issue_i;
            cnt  <= '0;
        end else if (last) begin
            busy <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge pclk) begin
        if (issue_i && !busy) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge pclk) begin
        din_q <= lcd_data_i;
        // din_q now holds the pin value from the last low cycle
        if (busy && req_q.rd && cnt == PHASE_W'(RD_LOW_CYC)) begin
            rdata_q <= din_q;
        end
    end

    assign lcd_cs_o      = !busy;
    assign lcd_rs_o      = busy ? req_q.rs : 1'b1;
    assign lcd_wr_o      = !(busy && !req_q.rd && cnt < PHASE_W'(WR_LOW_CYC));
    assign lcd_rd_o      = !(busy && req_q.rd && cnt < PHASE_W'(RD_LOW_CYC));
    assign lcd_data_oe_o = busy && !req_q.rd;
    assign lcd_data_o    = lcd_data_oe_o ? req_q.word : 16'h0000;
    assign done_o        = last;
    assign rdata_o       = rdata_q;

endmodule

/* lcd_top.sv */
// lcd controller top, connects init, fill, id, arbiter and bus timing stages
module lcd_top import lcd_pkg::*; (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        fill_start_i,
    input  fill_req_t   fill_i,
    input  logic        id_start_i,
    input  logic [15:0] lcd_data_i,
    output logic        lcd_rst_o,
    output logic        lcd_cs_o,
    output logic        lcd_rs_o,
    output logic        lcd_wr_o,
    output logic        lcd_rd_o,
    output logic        lcd_data_oe_o,
    output logic [15:0] lcd_data_o,
    output logic        init_done_o,
    output logic        fill_done_o,
    output logic        id_valid_o,
    output logic [23:0] id_o
);

    logic        init_issue, fill_issue, id_issue, bus_issue;
    bus_req_t    init_req, fill_req, id_req, bus_req;
    logic        init_wdone, fill_wdone, id_wdone, bus_done;
    logic        fill_go, id_go;        // forwarded starts
    logic        fill_busy, id_busy;
    logic [15:0] bus_rdata;

    lcd_init_seq u_init (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .done_i      (init_wdone),
        .lcd_rst_o   (lcd_rst_o),
        .issue_o     (init_issue),
        .req_o       (init_req),
        .init_done_o (init_done_o)
    );

    lcd_fill_engine u_fill (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .start_i     (fill_go),
        .fill_i      (fill_i),
        .done_i      (fill_wdone),
        .issue_o     (fill_issue),
        .req_o       (fill_req),
        .fill_done_o (fill_done_o),
        .busy_o      (fill_busy)
    );

    lcd_id_reader u_id (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .start_i    (id_go),
        .done_i     (id_wdone),
        .rdata_i    (bus_rdata),
        .issue_o    (id_issue),
        .req_o      (id_req),
        .id_o       (id_o),
        .id_valid_o (id_valid_o),
        .busy_o     (id_busy)
    );

    lcd_bus_arbiter u_arb (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .init_done_i  (init_done_o),
        .fill_start_i (fill_start_i),
        .id_start_i   (id_start_i),
        .fill_busy_i  (fill_busy),
        .id_busy_i    (id_busy),
        .fill_start_o (fill_go),
        .id_start_o   (id_go),
        .init_issue_i (init_issue),
        .fill_issue_i (fill_issue),
        .id_issue_i   (id_issue),
        .init_req_i   (init_req),
        .fill_req_i   (fill_req),
        .id_req_i     (id_req),
        .issue_o      (bus_issue),
        .req_o        (bus_req),
        .done_i       (bus_done),
        .init_done_o  (init_wdone),
        .fill_done_o  (fill_wdone),
        .id_done_o    (id_wdone)
    );

    lcd_bus_timing u_bus (
        .pclk          (pclk),
        .rst_n         (rst_n),
        .issue_i       (bus_issue),
        .req_i         (bus_req),
        .lcd_data_i    (lcd_data_i),
        .lcd_cs_o      (lcd_cs_o),
        .lcd_rs_o      (lcd_rs_o),
        .lcd_wr_o      (lcd_wr_o),
        .lcd_rd_o      (lcd_rd_o),
        .lcd_data_oe_o (lcd_data_oe_o),
        .lcd_data_o    (lcd_data_o),
        .done_o        (bus_done),
        .rdata_o       (bus_rdata)
    );

endmodule

/* lcd_top_assertions.sv */
// pin-level concurrent checks for the lcd controller, bound into lcd_top for simulation
module lcd_top_assertions import lcd_pkg::*; (
    input logic        pclk,
    input logic        rst_n,
    input logic        fill_start_i,
    input fill_req_t   fill_i,
    input logic        id_start_i,
    input logic        lcd_rst_o,
    input logic        lcd_cs_o,
    input logic        lcd_rs_o,
    input logic        lcd_wr_o,
    input logic        lcd_rd_o,
    input logic        lcd_data_oe_o,
    input logic [15:0] lcd_data_o,
    input logic        init_done_o,
    input logic        fill_done_o,
    input logic        id_valid_o,
    input logic [23:0] id_o
);

    logic               wr_q, rd_q, wr_fall, rd_fall;
    logic               fill_act, id_act;          // operation the bus is expected to carry
    int                 init_words, words, exp_area, dx, dy;
    logic [COORD_W-1:0] cx0, cx1, cy0, cy1;
    logic [COORD_W-1:0] ex0, ex1, ey0, ey1;
    rgb565_t            exp_pix;
    logic               exp_rs, wr_allowed, word_ok;
    lcd_word_u          exp_w, got_w;
    int                 err_cnt = 0;

    assign wr_fall = wr_q && !lcd_wr_o;
    assign rd_fall = rd_q && !lcd_rd_o;
    assign got_w   = lcd_data_o;

    // clamp to the panel first, ordering comes after
    assign cx0 = (fill_i.x0 > COORD_W'(H_RES - 1)) ? COORD_W'(H_RES - 1) : fill_i.x0;
    assign cx1 = (fill_i.x1 > COORD_W'(H_RES - 1)) ? COORD_W'(H_RES - 1) : fill_i.x1;
    assign cy0 = (fill_i.y0 > COORD_W'(V_RES - 1)) ? COORD_W'(V_RES - 1) : fill_i.y0;
    assign cy1 = (fill_i.y1 > COORD_W'(V_RES - 1)) ? COORD_W'(V_RES - 1) : fill_i.y1;
    assign dx  = (cx1 < cx0) ? int'(cx0 - cx1) : int'(cx1 - cx0);
    assign dy  = (cy1 < cy0) ? int'(cy0 - cy1) : int'(cy1 - cy0);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wr_q       <= 1'b1;
            rd_q       <= 1'b1;
            fill_act   <= 1'b0;
            id_act     <= 1'b0;
            init_words <= 0;
            words      <= 0;
        end else begin
            wr_q <= lcd_wr_o;
            rd_q <= lcd_rd_o;
            if (wr_fall || rd_fall) begin
                if (init_words < INIT_LEN) begin
                    init_words <= init_words + 1;
                end else begin
                    words <= words + 1;
                end
            end
            if (fill_done_o) fill_act <= 1'b0;
            if (id_valid_o) id_act <= 1'b0;
            if (init_done_o && !fill_act && !id_act) begin
                if (fill_start_i) begin    // fill wins a tie
                    fill_act <= 1'b1;
                    words    <= 0;
                    ex0      <= (cx1 < cx0) ? cx1 : cx0;
                    ex1      <= (cx1 < cx0) ? cx0 : cx1;
                    ey0      <= (cy1 < cy0) ? cy1 : cy0;
                    ey1      <= (cy1 < cy0) ? cy0 : cy1;
                    exp_pix  <= '{fill_i.color.r[7:3], fill_i.color.g[7:2], fill_i.color.b[7:3]};
                    exp_area <= (dx + 1) * (dy + 1);
                end else if (id_start_i) begin
                    id_act <= 1'b1;
                    words  <= 0;
                end
            end
        end
    end

    // next expected write word
    always_comb begin
        exp_w  = '0;
        exp_rs = 1'b1;
        if (init_words < INIT_LEN) begin
            exp_rs           = INIT_TABLE[init_words].rs;
            exp_w.cmd.opcode = INIT_TABLE[init_words].data;
        end else if (id_act) begin
            exp_rs           = 1'b0;
            exp_w.cmd.opcode = CMD_RDID;
        end else begin
            exp_rs = !(words == 0 || words == 5 || words == 10);
            case (words)
                0:       exp_w.cmd.opcode = CMD_CASET;
                1:       exp_w.cmd.opcode = 8'(ex0 >> 8);
                2:       exp_w.cmd.opcode = ex0[7:0];
                3:       exp_w.cmd.opcode = 8'(ex1 >> 8);
                4:       exp_w.cmd.opcode = ex1[7:0];
                5:       exp_w.cmd.opcode = CMD_PASET;
                6:       exp_w.cmd.opcode = 8'(ey0 >> 8);
                7:       exp_w.cmd.opcode = ey0[7:0];
                8:       exp_w.cmd.opcode = 8'(ey1 >> 8);
                9:       exp_w.cmd.opcode = ey1[7:0];
                10:      exp_w.cmd.opcode = CMD_RAMWR;
                default: exp_w.pix = exp_pix;
            endcase
        end
    end

    assign wr_allowed = (init_words < INIT_LEN) || fill_act || (id_act && words == 0);
    // pixel words are compared as rgb565, everything else as pad plus byte
    assign word_ok = (lcd_rs_o == exp_rs) &&
                     ((lcd_rs_o && fill_act && words >= FILL_CMD_WORDS) ?
                      (got_w.pix == exp_w.pix) : (got_w.cmd == exp_w.cmd));

    a_hold: assert property (@(posedge pclk)
        $rose(rst_n) |-> (!lcd_rst_o)[*RST_HOLD_CYC] ##1 lcd_rst_o)
        else begin err_cnt++; $error("panel reset not held low for %0d cycles", RST_HOLD_CYC); end
    a_hold_quiet: assert property (@(posedge pclk) disable iff (!rst_n)
        !lcd_rst_o |-> lcd_wr_o && lcd_rd_o)
        else begin err_cnt++; $error("bus strobe fell while panel reset was held"); end
    a_init_rise: assert property (@(posedge pclk) disable iff (!rst_n)
        $rose(init_done_o) |-> init_words == INIT_LEN)
        else begin err_cnt++; $error("init_done_o rose before the whole init table was written"); end
    a_init_stay: assert property (@(posedge pclk) disable iff (!rst_n)
        init_done_o |=> init_done_o)
        else begin err_cnt++; $error("init_done_o dropped after rising"); end
    a_wr_low: assert property (@(posedge pclk) disable iff (!rst_n)
        $fell(lcd_wr_o) |-> (!lcd_wr_o)[*WR_LOW_CYC] ##1 lcd_wr_o)
        else begin err_cnt++; $error("write strobe low phase has the wrong length"); end
    a_rd_low: assert property (@(posedge pclk) disable iff (!rst_n)
        $fell(lcd_rd_o) |-> (!lcd_rd_o)[*RD_LOW_CYC] ##1 lcd_rd_o)
        else begin err_cnt++; $error("read strobe low phase has the wrong length"); end
    a_cs: assert property (@(posedge pclk) disable iff (!rst_n)
        (!lcd_wr_o || !lcd_rd_o) |-> !lcd_cs_o)
        else begin err_cnt++; $error("strobe low while chip select is high"); end
    a_oe: assert property (@(posedge pclk) disable iff (!rst_n)
        (!lcd_wr_o |-> lcd_data_oe_o) and (!lcd_rd_o |-> !lcd_data_oe_o))
        else begin err_cnt++; $error("data output enable wrong for the strobe phase"); end
    a_wr_allowed: assert property (@(posedge pclk) disable iff (!rst_n)
        $fell(lcd_wr_o) |-> wr_allowed)
        else begin err_cnt++; $error("write word with no operation expecting one"); end
    a_word: assert property (@(posedge pclk) disable iff (!rst_n)
        $fell(lcd_wr_o) && wr_allowed |-> word_ok)
        else begin
            err_cnt++;
            $error("Mismatch lcd_rs_o/lcd_data_o: expected %h, got %h",
                   $sampled({exp_rs, exp_w}), $sampled({lcd_rs_o, lcd_data_o}));
        end
    a_rd_allowed: assert property (@(posedge pclk) disable iff (!rst_n)
        $fell(lcd_rd_o) |-> id_act && words >= 1 && words <= 4)
        else begin err_cnt++; $error("read cycle outside an ID request"); end
    a_fill_done: assert property (@(posedge pclk) disable iff (!rst_n)
        fill_done_o |-> fill_act && words == FILL_CMD_WORDS + exp_area)
        else begin err_cnt++; $error("fill_done_o pulsed without the full word count"); end
    a_id_done: assert property (@(posedge pclk) disable iff (!rst_n)
        id_valid_o |-> id_act && words == 5)
        else begin err_cnt++; $error("id_valid_o pulsed without one command and four reads"); end
    a_id_value: assert property (@(posedge pclk) disable iff (!rst_n)
        id_valid_o |-> id_o == 24'h548066)
        else begin
            err_cnt++;
            $error("Mismatch id_o: expected %h, got %h", 24'h548066, $sampled(id_o));
        end

endmodule

bind lcd_top lcd_top_assertions u_chk (.*);

/* tb_lcd_top.sv */
// testbench for lcd_top, drives init, fill and id traffic while the bound checker watches the pins
module tb_lcd_top import lcd_pkg::*; ();

    logic        pclk = 1'b0;
    logic        rst_n;
    logic        fill_start, id_start;
    fill_req_t   fill_req;
    logic [15:0] lcd_din;
    logic        lcd_rst, lcd_cs, lcd_rs, lcd_wr, lcd_rd, lcd_oe;
    logic [15:0] lcd_dout;
    logic        init_done, fill_done, id_valid;
    logic [23:0] id_val;
    logic [15:0] id_words [4] = '{16'h0000, 16'h0054, 16'h0080, 16'h0066};
    int          rd_idx = 0;
    int          cyc = 0;
    int          n_tests = 0;
    int          n_fail = 0;
    int          err_mark = 0;
    // init words, 5 fills of up to 27 words, 2 id reads of 5 words, 6 cycles each, doubled
    int          limit_cyc = (INIT_LEN + 5 * (FILL_CMD_WORDS + 16) + 2 * 5) * 6 * 2;

    always #4 pclk = ~pclk;

    lcd_top u_dut (
        .pclk          (pclk),
        .rst_n         (rst_n),
        .fill_start_i  (fill_start),
        .fill_i        (fill_req),
        .id_start_i    (id_start),
        .lcd_data_i    (lcd_din),
        .lcd_rst_o     (lcd_rst),
        .lcd_cs_o      (lcd_cs),
        .lcd_rs_o      (lcd_rs),
        .lcd_wr_o      (lcd_wr),
        .lcd_rd_o      (lcd_rd),
        .lcd_data_oe_o (lcd_oe),
        .lcd_data_o    (lcd_dout),
        .init_done_o   (init_done),
        .fill_done_o   (fill_done),
        .id_valid_o    (id_valid),
        .id_o          (id_val)
    );

    // panel model, each read gets the next id word
    always @(negedge lcd_rd) begin
        #1;
        lcd_din = id_words[rd_idx];
        rd_idx  = (rd_idx + 1) % 4;
    end

    always @(posedge pclk) begin
        cyc <= cyc + 1;
        if (cyc >= limit_cyc) begin
            $display("timeout: no done strobe within %0d cycles", limit_cyc);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic tick;
        @(posedge pclk);
        #1;
    endtask

    task automatic pulse_starts(input logic do_fill, input logic do_id, input fill_req_t r);
        tick();
        fill_start = do_fill;
        id_start   = do_id;
        fill_req   = r;
        tick();
        fill_start = 1'b0;
        id_start   = 1'b0;
    endtask

    // random rectangle of 2..4 pixels per side inside the panel, optionally with swapped corners
    function automatic fill_req_t rand_rect(input logic swap);
        fill_req_t          r;
        logic [COORD_W-1:0] xa, ya, xb, yb;
        xa      = COORD_W'($urandom % (H_RES - 3));
        ya      = COORD_W'($urandom % (V_RES - 3));
        xb      = xa + COORD_W'(1 + $urandom % 3);
        yb      = ya + COORD_W'(1 + $urandom % 3);
        r.color = rgb888_t'(24'($urandom));
        r.x0    = swap ? xb : xa;
        r.x1    = swap ? xa : xb;
        r.y0    = swap ? yb : ya;
        r.y1    = swap ? ya : yb;
        return r;
    endfunction

    task automatic end_test(input string name);
        int errs;
        errs     = u_dut.u_chk.err_cnt - err_mark;
        err_mark = u_dut.u_chk.err_cnt;
        n_tests++;
        if (errs != 0) n_fail++;
        $display("test %-18s %s (%0d assertion errors)", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        void'($urandom(32'h75ec_f647));
        rst_n      = 1'b0;
        fill_start = 1'b0;
        id_start   = 1'b0;
        fill_req   = '0;
        lcd_din    = '0;
        repeat (5) @(posedge pclk);
        #1;
        rst_n = 1'b1;

        // both starts during the reset hold, nothing may reach the bus
        repeat (3) tick();
        pulse_starts(1'b1, 1'b1, rand_rect(1'b0));
        do @(negedge pclk); while (!lcd_rst);
        end_test("reset_hold");

        repeat (6) tick();
        pulse_starts(1'b1, 1'b0, rand_rect(1'b0));    // init still running
        do @(negedge pclk); while (!init_done);
        end_test("init_table");

        for (int i = 0; i < 3; i++) begin
            pulse_starts(1'b1, 1'b0, rand_rect(1'b0));
            do @(negedge pclk); while (!fill_done);
            end_test($sformatf("fill_random_%0d", i));
        end

        pulse_starts(1'b1, 1'b0, rand_rect(1'b1));
        do @(negedge pclk); while (!fill_done);
        end_test("fill_swapped");

        pulse_starts(1'b0, 1'b1, '0);
        do @(negedge pclk); while (!id_valid);
        end_test("id_read");

        // tie, only the fill may run
        pulse_starts(1'b1, 1'b1, rand_rect(1'b0));
        do @(negedge pclk); while (!fill_done);
        repeat (20) @(negedge pclk);
        end_test("same_cycle_start");

        pulse_starts(1'b0, 1'b1, '0);
        repeat (10) tick();
        pulse_starts(1'b1, 1'b0, rand_rect(1'b0));    // id read still owns the bus
        do @(negedge pclk); while (!id_valid);
        repeat (20) @(negedge pclk);
        end_test("start_while_busy");

        $display("tests %0d, failed %0d, assertion errors %0d",
                 n_tests, n_fail, u_dut.u_chk.err_cnt);
        if (n_fail == 0 && u_dut.u_chk.err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
lcd_pkg.sv
lcd_init_seq.sv
lcd_fill_engine.sv
lcd_id_reader.sv
lcd_bus_arbiter.sv
lcd_bus_timing.sv
lcd_top.sv
lcd_top_assertions.sv
tb_lcd_top.sv
